// ==== hdl/matrix_pkg.sv ====
package matrix_pkg;

    // displayed digit, 6 and 7 show the question mark
    typedef logic [2:0] digit_t;

    // scanned row, 0 is the top row
    typedef logic [2:0] row_idx_t;

    // one column or row-select pattern
    typedef logic [7:0] line_t;

    typedef struct packed {
        line_t row_sel;
        line_t col_red;
        line_t col_green;
    } matrix_drive_t;

    // single field for now, room for more later
    typedef struct packed {
        digit_t start_digit;
    } start_cmd_t;

    typedef enum logic [0:0] {
        cd_idle,
        cd_run
    } cd_state_t;

    // cycles per scanned row
    localparam int SCAN_CYCLES = 4;

    // cycles each digit is held, two full frames
    localparam int DIGIT_CYCLES = 64;

    localparam int SCAN_W  = $clog2(SCAN_CYCLES);
    localparam int DIGIT_W = $clog2(DIGIT_CYCLES);

    localparam int NUM_ROWS = 8;

    // all rows off, all columns dark
    localparam matrix_drive_t BLANK_DRIVE = '{
        row_sel:   '1,
        col_red:   '0,
        col_green: '0
    };

endpackage

// ==== hdl/countdown_fsm.sv ====
module countdown_fsm import matrix_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  start_cmd_t cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic       abort,
    input  logic       digit_tick,
    output logic       run,
    output logic       restart,
    output digit_t     digit,
    output logic       expired
);

    cd_state_t state;
    logic      accept;
    logic      last_digit;

    assign cmd_ready = (state == cd_idle);
    assign run       = (state == cd_run);
    assign accept    = cmd_valid && cmd_ready;

    // abort wins over a start offered in the same cycle
    assign restart    = accept && !abort;
    assign last_digit = (digit == digit_t'(0));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= cd_idle;
            digit   <= '0;
            expired <= 1'b0;
        end
        else
        begin
            expired <= 1'b0;
            if (abort)
            begin
                state <= cd_idle;
            end
            else
            begin
                case (state)
                    cd_idle:
                    begin
                        if (accept)
                        begin
                            state <= cd_run;
                            digit <= cmd.start_digit;
                        end
                    end
                    cd_run:
                    begin
                        if (digit_tick)
                        begin
                            if (last_digit)
                            begin
                                // zero has had its full period
                                state   <= cd_idle;
                                expired <= 1'b1;
                            end
                            else
                            begin
                                digit <= digit - digit_t'(1);
                            end
                        end
                    end
                    default:
                    begin
                        state <= cd_idle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/period_timer.sv ====
module period_timer import matrix_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic restart,
    output logic scan_tick,
    output logic digit_tick
);

    logic [SCAN_W-1:0]  scan_cnt;
    logic [DIGIT_W-1:0] digit_cnt;
    logic               scan_last;
    logic               digit_last;

    assign scan_last  = (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));
    assign digit_last = (digit_cnt == DIGIT_W'(DIGIT_CYCLES - 1));

    // strobes only mean something while running
    assign scan_tick  = run && scan_last;
    assign digit_tick = run && digit_last;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            digit_cnt <= '0;
        end
        else if (restart || !run)
        begin
            scan_cnt  <= '0;
            digit_cnt <= '0;
        end
        else
        begin
            if (scan_last)
                scan_cnt <= '0;
            else
                scan_cnt <= scan_cnt + 1'b1;

            if (digit_last)
                digit_cnt <= '0;
            else
                digit_cnt <= digit_cnt + 1'b1;
        end
    end

endmodule

// ==== hdl/digit_glyph_rom.sv ====
module digit_glyph_rom import matrix_pkg::*;
(
    input  digit_t   digit,
    input  row_idx_t row_idx,
    output line_t    red,
    output line_t    green
);

    line_t shape;
    logic  use_red;
    logic  use_green;

    always_comb
    begin
        shape = '0;
        case (digit)
            3'd0:
            begin
                case (row_idx)
                    3'd1, 3'd7:             shape = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4,
                    3'd5, 3'd6:             shape = 8'b0100_0010;
                    default:                shape = '0;
                endcase
            end
            3'd1:
            begin
                case (row_idx)
                    3'd3:                   shape = 8'b0011_1000;
                    3'd7:                   shape = 8'b0111_1110;
                    3'd1, 3'd2, 3'd4,
                    3'd5, 3'd6:             shape = 8'b0001_1000;
                    default:                shape = '0;
                endcase
            end
            3'd2:
            begin
                case (row_idx)
                    3'd1:                   shape = 8'b0011_1100;
                    3'd2:                   shape = 8'b0110_0110;
                    3'd3:                   shape = 8'b0000_0110;
                    3'd4:                   shape = 8'b0000_1100;
                    3'd5:                   shape = 8'b0011_0000;
                    3'd6:                   shape = 8'b0110_0000;
                    3'd7:                   shape = 8'b0111_1110;
                    default:                shape = '0;
                endcase
            end
            3'd3:
            begin
                case (row_idx)
                    3'd1, 3'd7:             shape = 8'b0011_1100;
                    3'd2, 3'd6:             shape = 8'b0110_0110;
                    3'd3, 3'd5:             shape = 8'b0000_0110;
                    3'd4:                   shape = 8'b0001_1100;
                    default:                shape = '0;
                endcase
            end
            3'd4:
            begin
                case (row_idx)
                    3'd1, 3'd6, 3'd7:       shape = 8'b0000_1100;
                    3'd2:                   shape = 8'b0001_1100;
                    3'd3:                   shape = 8'b0010_1100;
                    3'd4:                   shape = 8'b0100_1100;
                    3'd5:                   shape = 8'b0111_1110;
                    default:                shape = '0;
                endcase
            end
            3'd5:
            begin
                case (row_idx)
                    3'd1:                   shape = 8'b0111_1110;
                    3'd2:                   shape = 8'b0110_0000;
                    3'd3:                   shape = 8'b0111_1100;
                    3'd4, 3'd5:             shape = 8'b0000_0110;
                    3'd6:                   shape = 8'b0110_0110;
                    3'd7:                   shape = 8'b0011_1100;
                    default:                shape = '0;
                endcase
            end
            default:
            begin
                // question mark for 6 and 7
                case (row_idx)
                    3'd0:                   shape = 8'b0111_1000;
                    3'd1:                   shape = 8'b1100_1100;
                    3'd2:                   shape = 8'b0000_1100;
                    3'd3:                   shape = 8'b0001_1000;
                    3'd4, 3'd6:             shape = 8'b0011_0000;
                    default:                shape = '0;
                endcase
            end
        endcase
    end

    // 4..7 red, 2..3 yellow, 0..1 green
    assign use_red   = (digit >= digit_t'(2));
    assign use_green = (digit <= digit_t'(3));

    assign red   = use_red ? shape : '0;
    assign green = use_green ? shape : '0;

endmodule

// ==== hdl/matrix_row_scanner.sv ====
module matrix_row_scanner import matrix_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          run,
    input  logic          scan_tick,
    input  line_t         red,
    input  line_t         green,
    output row_idx_t      row_idx,
    output matrix_drive_t drive
);

    line_t row_onehot;

    assign row_onehot = line_t'(1) << row_idx;

    // row counter restarts at the top on every new run
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (!run)
            row_idx <= '0;
        else if (scan_tick)
            row_idx <= (row_idx == row_idx_t'(NUM_ROWS - 1)) ? '0 : row_idx + 1'b1;
    end

    // registered pin drive, one cycle behind row and digit
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            drive <= BLANK_DRIVE;
        end
        else if (run)
        begin
            drive.row_sel   <= ~row_onehot;
            drive.col_red   <= red;
            drive.col_green <= green;
        end
        else
        begin
            drive <= BLANK_DRIVE;
        end
    end

endmodule

// ==== hdl/countdown_matrix.sv ====
module countdown_matrix import matrix_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  start_cmd_t    cmd,
    input  logic          cmd_valid,
    output logic          cmd_ready,
    input  logic          abort,
    output logic          busy,
    output logic          expired,
    output matrix_drive_t drive
);

    logic     run;
    logic     restart;
    logic     scan_tick;
    logic     digit_tick;
    digit_t   digit;
    row_idx_t row_idx;
    line_t    red;
    line_t    green;

    countdown_fsm i_countdown_fsm (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .abort      (abort),
        .digit_tick (digit_tick),
        .run        (run),
        .restart    (restart),
        .digit      (digit),
        .expired    (expired)
    );

    period_timer i_period_timer (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .restart    (restart),
        .scan_tick  (scan_tick),
        .digit_tick (digit_tick)
    );

    digit_glyph_rom i_digit_glyph_rom (
        .digit   (digit),
        .row_idx (row_idx),
        .red     (red),
        .green   (green)
    );

    matrix_row_scanner i_matrix_row_scanner (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .scan_tick (scan_tick),
        .red       (red),
        .green     (green),
        .row_idx   (row_idx),
        .drive     (drive)
    );

    assign busy = run;

endmodule

// ==== tb/countdown_matrix_assert.sv ====
module countdown_matrix_assert import matrix_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input logic          busy,
    input logic          cmd_ready,
    input logic          expired,
    input matrix_drive_t drive
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // one row lit in the cycle after a busy cycle
    row_sel_one_cold: assert property (@(posedge clk) disable iff (rst)
        busy |=> $onehot(~drive.row_sel))
    else
    begin
        fail_count++;
        $error("row_sel is not one-cold after a busy cycle");
    end

    expired_single_pulse: assert property (@(posedge clk) disable iff (rst)
        expired |=> !expired)
    else
    begin
        fail_count++;
        $error("expired stayed high for two cycles");
    end

    ready_is_not_busy: assert property (@(posedge clk) disable iff (rst)
        cmd_ready == !busy)
    else
    begin
        fail_count++;
        $error("cmd_ready is not the inverse of busy");
    end

endmodule

bind countdown_matrix countdown_matrix_assert i_countdown_matrix_assert (.*);

// ==== tb/countdown_matrix_tb.sv ====
module countdown_matrix_tb import matrix_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CMDS       = 24;
    localparam int ACCEPT_TIMEOUT = 9 * DIGIT_CYCLES;
    localparam int IDLE_TIMEOUT   = 9 * DIGIT_CYCLES;

    logic          clk;
    logic          rst;
    start_cmd_t    cmd;
    logic          cmd_valid;
    logic          cmd_ready;
    logic          abort;
    logic          busy;
    logic          expired;
    matrix_drive_t drive;

    // reference model state
    logic m_busy;
    logic m_expired;
    int   m_digit;
    int   m_phase;
    int   m_start;
    logic last_accept;
    int   cycle;
    int   accept_cycle;

    countdown_matrix i_countdown_matrix (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .abort     (abort),
        .busy      (busy),
        .expired   (expired),
        .drive     (drive)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "stopping after the first failure");
    endtask

    task automatic compare_values(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("error %s expected %0h actual %0h", what, expected, actual);
            stop_with_failure();
        end
    endtask

    // bitmaps with row 0 in the top byte
    function automatic line_t glyph_row(int d, int r);
        logic [63:0] bitmap;
        case (d)
            0:       bitmap = 64'h003C_4242_4242_423C;
            1:       bitmap = 64'h0018_1838_1818_187E;
            2:       bitmap = 64'h003C_6606_0C30_607E;
            3:       bitmap = 64'h003C_6606_1C06_663C;
            4:       bitmap = 64'h000C_1C2C_4C7E_0C0C;
            5:       bitmap = 64'h007E_607C_0606_663C;
            default: bitmap = 64'h78CC_0C18_3000_3000;
        endcase
        return bitmap[8 * (7 - r) +: 8];
    endfunction

    // one clock cycle of model update and output checks
    task automatic step();
        int    row;
        line_t shape;
        line_t exp_row_sel;
        line_t exp_red;
        line_t exp_green;
        @(posedge clk);
        cycle++;
        exp_row_sel = '1;
        exp_red     = '0;
        exp_green   = '0;
        if (m_busy)
        begin
            row         = (m_phase / SCAN_CYCLES) % NUM_ROWS;
            shape       = glyph_row(m_digit, row);
            exp_row_sel = ~(line_t'(1) << row);
            case (m_digit)
                0, 1:    exp_green = shape;
                2, 3:
                begin
                    exp_red   = shape;
                    exp_green = shape;
                end
                default: exp_red = shape;
            endcase
        end
        m_expired   = 1'b0;
        last_accept = 1'b0;
        if (abort)
            m_busy = 1'b0;
        else if (!m_busy)
        begin
            if (cmd_valid)
            begin
                m_busy       = 1'b1;
                m_digit      = cmd.start_digit;
                m_start      = cmd.start_digit;
                m_phase      = 0;
                last_accept  = 1'b1;
                accept_cycle = cycle;
            end
        end
        else
        begin
            m_phase++;
            // a start digit d runs for d+1 digit periods in total
            if (cycle - accept_cycle == (m_start + 1) * DIGIT_CYCLES)
            begin
                m_busy    = 1'b0;
                m_expired = 1'b1;
            end
            else if (m_phase == DIGIT_CYCLES)
            begin
                m_phase = 0;
                m_digit--;
            end
        end
        @(negedge clk);
        compare_values("busy", m_busy, busy);
        compare_values("cmd_ready", !m_busy, cmd_ready);
        compare_values("expired", m_expired, expired);
        compare_values("row_sel", exp_row_sel, drive.row_sel);
        compare_values("red columns", exp_red, drive.col_red);
        compare_values("green columns", exp_green, drive.col_green);
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        step();
        while (!last_accept)
        begin
            n++;
            if (n > ACCEPT_TIMEOUT)
            begin
                $display("start command was never accepted");
                stop_with_failure();
            end
            else
                step();
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy)
        begin
            n++;
            if (n > IDLE_TIMEOUT)
            begin
                $display("countdown did not finish in time");
                stop_with_failure();
            end
            else
                step();
        end
    endtask

    initial
    begin
        int mode;
        int gap;
        void'($urandom(83461));
        rst       = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        abort     = 1'b0;
        m_busy    = 1'b0;
        m_expired = 1'b0;
        m_digit   = 0;
        m_phase   = 0;
        m_start   = 0;
        cycle     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_values("row_sel after reset", 8'hFF, drive.row_sel);
        compare_values("red after reset", 0, drive.col_red);
        compare_values("green after reset", 0, drive.col_green);
        compare_values("busy after reset", 0, busy);
        compare_values("cmd_ready after reset", 1, cmd_ready);
        for (int i = 0; i < NUM_CMDS; i++)
        begin
            gap = $urandom_range(0, 4);
            repeat (gap) step();
            cmd.start_digit = digit_t'($urandom_range(0, 7));
            cmd_valid       = 1'b1;
            wait_accept();
            cmd_valid = 1'b0;
            mode = $urandom_range(0, 3);
            if (mode == 0)
            begin
                repeat ($urandom_range(0, (m_start + 1) * DIGIT_CYCLES - 2)) step();
                abort = 1'b1;
                step();
                abort = 1'b0;
            end
            else if (mode != 1)
                wait_idle();
            // mode 1 offers the next command while this one still runs
        end
        wait_idle();
        repeat (4) step();
        if (i_countdown_matrix.i_countdown_matrix_assert.fail_count == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("concurrent assertions reported failures");
            stop_with_failure();
        end
    end

endmodule

// ==== countdown_matrix.f ====
hdl/matrix_pkg.sv
hdl/countdown_fsm.sv
hdl/period_timer.sv
hdl/digit_glyph_rom.sv
hdl/matrix_row_scanner.sv
hdl/countdown_matrix.sv
tb/countdown_matrix_assert.sv
tb/countdown_matrix_tb.sv

// ==== Bender.yml ====
package:
  name: countdown_matrix

sources:
  - files:
      - hdl/matrix_pkg.sv
      - hdl/countdown_fsm.sv
      - hdl/period_timer.sv
      - hdl/digit_glyph_rom.sv
      - hdl/matrix_row_scanner.sv
      - hdl/countdown_matrix.sv
  - target: test
    files:
      - tb/countdown_matrix_assert.sv
      - tb/countdown_matrix_tb.sv
